// ==== verif/decode_stimulus.txt ====
// if_valid if_pc imem_valid imem_data stall flush ex_mem_re ex_rd | ex_valid ctrl alu_op wb_sel
// mem_size imm ex_pc ex_inst hazard  (ctrl = rf_we mem_we mem_re branch jump jump_reg op1_pc op2_imm)
1 00001000 0 00000000 0 0 0 00  0 00 0 0 0 00000000 00000000 00000000 0
1 00001004 1 123450B7 0 0 0 00  1 81 0 1 0 12345000 00001000 123450B7 0
1 00001008 1 FFFFF117 0 0 0 00  1 83 0 0 0 FFFFF000 00001004 FFFFF117 0
1 0000100C 1 FF9FF0EF 0 0 0 00  1 8B 0 2 0 FFFFFFF8 00001008 FF9FF0EF 0
1 00001010 1 01008067 0 0 0 00  1 8D 0 2 0 00000010 0000100C 01008067 0
1 00001014 1 00208863 0 0 0 00  1 10 A 0 0 00000010 00001010 00208863 0
1 00001018 1 FE419EE3 0 0 0 00  1 10 B 0 0 FFFFFFFC 00001014 FE419EE3 0
1 0000101C 1 0020C463 0 0 0 00  1 10 3 0 0 00000008 00001018 0020C463 0
1 00001020 1 0020D463 0 0 0 00  1 10 C 0 0 00000008 0000101C 0020D463 0
1 00001024 1 0020E463 0 0 0 00  1 10 4 0 0 00000008 00001020 0020E463 0
1 00001028 1 0020F463 0 0 0 00  1 10 D 0 0 00000008 00001024 0020F463 0
1 0000102C 1 FFF08283 0 0 0 00  1 A1 0 3 0 FFFFFFFF 00001028 FFF08283 0
1 00001030 1 FFF09283 0 0 0 00  1 A1 0 3 2 FFFFFFFF 0000102C FFF09283 0
1 00001034 1 0040A283 0 0 0 00  1 A1 0 3 4 00000004 00001030 0040A283 0
1 00001038 1 0040C283 0 0 0 00  1 A1 0 3 1 00000004 00001034 0040C283 0
1 0000103C 1 0040D283 0 0 0 00  1 A1 0 3 3 00000004 00001038 0040D283 0
1 00001040 1 00208423 0 0 0 00  1 41 0 0 0 00000008 0000103C 00208423 0
1 00001044 1 FE209E23 0 0 0 00  1 41 0 0 2 FFFFFFFC 00001040 FE209E23 0
1 00001048 1 0020A423 0 0 0 00  1 41 0 0 4 00000008 00001044 0020A423 0
1 0000104C 1 FFE08193 0 0 0 00  1 81 0 0 0 FFFFFFFE 00001048 FFE08193 0
1 00001050 1 0050A193 0 0 0 00  1 81 3 0 0 00000005 0000104C 0050A193 0
1 00001054 1 0050B193 0 0 0 00  1 81 4 0 0 00000005 00001050 0050B193 0
1 00001058 1 0050C193 0 0 0 00  1 81 5 0 0 00000005 00001054 0050C193 0
1 0000105C 1 0050E193 0 0 0 00  1 81 8 0 0 00000005 00001058 0050E193 0
1 00001060 1 0050F193 0 0 0 00  1 81 9 0 0 00000005 0000105C 0050F193 0
1 00001064 1 00309193 0 0 0 00  1 81 2 0 0 00000003 00001060 00309193 0
1 00001068 1 0030D193 0 0 0 00  1 81 6 0 0 00000003 00001064 0030D193 0
1 0000106C 1 4030D193 0 0 0 00  1 81 7 0 0 00000403 00001068 4030D193 0
1 00001070 1 002081B3 0 0 0 00  1 80 0 0 0 00208000 0000106C 002081B3 0
1 00001074 1 402081B3 0 0 0 00  1 80 1 0 0 40208000 00001070 402081B3 0
1 00001078 1 002091B3 0 0 0 00  1 80 2 0 0 00209000 00001074 002091B3 0
1 0000107C 1 0020A1B3 0 0 0 00  1 80 3 0 0 0020A000 00001078 0020A1B3 0
1 00001080 1 0020B1B3 0 0 0 00  1 80 4 0 0 0020B000 0000107C 0020B1B3 0
1 00001084 1 0020C1B3 0 0 0 00  1 80 5 0 0 0020C000 00001080 0020C1B3 0
1 00001088 1 0020D1B3 0 0 0 00  1 80 6 0 0 0020D000 00001084 0020D1B3 0
1 0000108C 1 4020D1B3 0 0 0 00  1 80 7 0 0 4020D000 00001088 4020D1B3 0
1 00001090 1 0020E1B3 0 0 0 00  1 80 8 0 0 0020E000 0000108C 0020E1B3 0
1 00001094 1 0020F1B3 0 0 0 00  1 80 9 0 0 0020F000 00001090 0020F1B3 0
1 00001098 1 0040A283 0 1 0 00  0 01 0 3 4 00000004 00001094 00000013 0
1 0000109C 1 0020A423 1 0 0 00  1 41 0 0 4 00000008 00001098 0020A423 0
1 0000109C 1 002081B3 1 0 0 00  1 41 0 0 4 00000008 00001098 0020A423 0
1 0000109C 1 0050A193 1 0 0 00  1 41 0 0 4 00000008 00001098 0020A423 0
1 0000109C 1 0020C1B3 0 0 0 00  1 41 0 0 4 00000008 00001098 0020A423 0
1 000010A0 1 002081B3 0 0 1 01  1 80 0 0 0 00208000 0000109C 002081B3 1
1 000010A4 1 0020A1B3 0 0 1 02  1 80 3 0 0 0020A000 000010A0 0020A1B3 1
1 000010A8 1 00208863 0 0 1 02  1 10 A 0 0 00000010 000010A4 00208863 1
1 000010AC 1 0050A193 0 0 1 05  1 81 3 0 0 00000005 000010A8 0050A193 0
0 00000000 0 00000013 0 0 0 00  0 81 0 0 0 00000000 000010AC 00000013 1
0 00000000 0 00000000 0 0 0 00  0 00 0 0 0 00000000 00000000 00000000 0

// ==== rv_decode.f ====
common/rv_decode_pkg.sv
design/id_pipe_reg.sv
design/inst_buffer.sv
decoder/inst_decoder.sv
decoder/imm_gen.sv
design/hazard_detect.sv
design/decode_stage.sv
verif/tb_clock_gen.sv
verif/decode_stage_assertions.sv
verif/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the decode stage testbench with Verilator, run it and decide pass or fail from its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module decode_stage_tb -f rv_decode.f -o decode_stage_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/decode_stage_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "test passed"; then
	exit 0
else
	exit 1
fi

// ==== verif/decode_stage_tb.sv ====
// testbench for decode_stage that replays the stimulus file one line per cycle and checks outputs
module decode_stage_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import rv_decode_pkg::*;

	localparam int fields    = 17;
	localparam int max_lines = 256;

	logic      clk;
	logic      rstn;
	logic      if_valid;
	word_t     if_pc;
	word_t     if_pc_plus;
	logic      imem_valid;
	inst_t     imem_data;
	logic      stall;
	logic      flush;
	logic      ex_mem_re;
	reg_addr_t ex_rd;

	logic      ex_valid, rf_we, mem_we, mem_re, branch, jump, jump_reg;
	logic      alu_op1_pc, alu_op2_imm, hazard;
	inst_t     ex_inst;
	reg_addr_t rs1, rs2, rd;
	alu_op_e   alu_op;
	wb_sel_e   wb_sel;
	mem_size_e mem_size;
	word_t     ex_pc, ex_pc_plus, imm;

	logic [31:0] stim [0:fields*max_lines-1];
	int          n_lines;
	// pc_plus held by the stage register, zero out of reset
	word_t       captured_pc_plus;

	tb_clock_gen u_clock_gen (
		.clk  (clk),
		.rstn (rstn)
	);

	decode_stage UUT (
		.clk (clk), .rstn (rstn), .if_valid (if_valid), .if_pc (if_pc),
		.if_pc_plus (if_pc_plus), .imem_valid (imem_valid), .imem_data (imem_data),
		.stall (stall), .flush (flush), .ex_mem_re (ex_mem_re), .ex_rd (ex_rd),
		.ex_valid (ex_valid), .rf_we (rf_we), .mem_we (mem_we), .mem_re (mem_re),
		.branch (branch), .jump (jump), .jump_reg (jump_reg), .alu_op1_pc (alu_op1_pc),
		.alu_op2_imm (alu_op2_imm), .ex_inst (ex_inst), .rs1 (rs1), .rs2 (rs2), .rd (rd),
		.alu_op (alu_op), .wb_sel (wb_sel), .mem_size (mem_size), .ex_pc (ex_pc),
		.ex_pc_plus (ex_pc_plus), .imm (imm), .hazard (hazard)
	);

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error: %s expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_inst(input string name, input inst_t exp, input inst_t act);
		if (act !== exp) begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
		if (act !== exp) begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_wb(input string name, input wb_sel_e exp, input wb_sel_e act);
		if (act !== exp) begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_size(input string name, input mem_size_e exp, input mem_size_e act);
		if (act !== exp) begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp) begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic idle_inputs();
		if_valid   = 1'b0;
		if_pc      = '0;
		if_pc_plus = '0;
		imem_valid = 1'b0;
		imem_data  = '0;
		stall      = 1'b0;
		flush      = 1'b0;
		ex_mem_re  = 1'b0;
		ex_rd      = '0;
	endtask

	task automatic drive_line(input int k);
		int b;
		b          = k * fields;
		if_valid   = stim[b][0];
		if_pc      = stim[b+1];
		if_pc_plus = stim[b+1] + 32'd4;
		imem_valid = stim[b+2][0];
		imem_data  = stim[b+3];
		stall      = stim[b+4][0];
		flush      = stim[b+5][0];
		ex_mem_re  = stim[b+6][0];
		ex_rd      = stim[b+7][4:0];
	endtask

	task automatic check_line(input int k);
		int          b;
		logic [7:0]  ctrl;
		inst_t       exp_inst;
		string       tag;
		b        = k * fields + 8;
		ctrl     = stim[b+1][7:0];
		exp_inst = stim[b+7];
		tag      = $sformatf("decode line %0d", k);
		check_bit({tag, " ex_valid"}, stim[b][0], ex_valid);
		check_bit({tag, " rf_we"}, ctrl[7], rf_we);
		check_bit({tag, " mem_we"}, ctrl[6], mem_we);
		check_bit({tag, " mem_re"}, ctrl[5], mem_re);
		check_bit({tag, " branch"}, ctrl[4], branch);
		check_bit({tag, " jump"}, ctrl[3], jump);
		check_bit({tag, " jump_reg"}, ctrl[2], jump_reg);
		check_bit({tag, " alu_op1_pc"}, ctrl[1], alu_op1_pc);
		check_bit({tag, " alu_op2_imm"}, ctrl[0], alu_op2_imm);
		check_alu({tag, " alu_op"}, alu_op_e'(stim[b+2][3:0]), alu_op);
		check_wb({tag, " wb_sel"}, wb_sel_e'(stim[b+3][1:0]), wb_sel);
		check_size({tag, " mem_size"}, mem_size_e'(stim[b+4][2:0]), mem_size);
		check_word({tag, " imm"}, stim[b+5], imm);
		check_word({tag, " ex_pc"}, stim[b+6], ex_pc);
		check_word({tag, " ex_pc_plus"}, captured_pc_plus, ex_pc_plus);
		check_inst({tag, " ex_inst"}, exp_inst, ex_inst);
		check_bit({tag, " hazard"}, stim[b+8][0], hazard);
		// register fields follow the instruction format
		if (!flush) begin
			check_reg({tag, " rs1"}, exp_inst[19:15], rs1);
			check_reg({tag, " rs2"}, exp_inst[24:20], rs2);
			check_reg({tag, " rd"}, exp_inst[11:7], rd);
		end
	endtask

	task automatic check_reset();
		check_bit("reset ex_valid", 1'b0, ex_valid);
		check_bit("reset rf_we", 1'b0, rf_we);
		check_bit("reset mem_we", 1'b0, mem_we);
		check_bit("reset mem_re", 1'b0, mem_re);
		check_bit("reset branch", 1'b0, branch);
		check_bit("reset jump", 1'b0, jump);
		check_bit("reset hazard", 1'b0, hazard);
	endtask

	// watchdog sized from the number of stimulus lines
	initial begin
		int timeout;
		wait (n_lines > 0);
		@(posedge clk);
		timeout = (n_lines + 3) * 4 + 40;
		#(timeout);
		$display("watchdog expired before the stimulus finished");
		stop_run();
	end

	initial begin
		n_lines          = 0;
		captured_pc_plus = '0;
		// valid fetch during reset must not leak through
		if_valid   = 1'b1;
		if_pc      = 32'h0000_0ff0;
		if_pc_plus = 32'h0000_0ff4;
		imem_valid = 1'b1;
		imem_data  = 32'h0020_81b3;
		stall      = 1'b0;
		flush      = 1'b0;
		ex_mem_re  = 1'b0;
		ex_rd      = '0;
		for (int i = 0; i < fields * max_lines; i++) begin
			stim[i] = 32'hffff_ffff;
		end
		$readmemh("verif/decode_stimulus.txt", stim);
		while ((n_lines < max_lines) && (stim[n_lines * fields] !== 32'hffff_ffff)) begin
			n_lines++;
		end
		if (n_lines == 0) begin
			$display("no stimulus lines were read from the stimulus file");
			stop_run();
		end
		repeat (2) @(posedge clk);
		#3;
		check_reset();
		idle_inputs();
		for (int k = 0; k < n_lines; k++) begin
			@(posedge clk);
			#1;
			drive_line(k);
			#2;
			check_line(k);
			// the stage register takes pc_plus at the next edge unless stalled
			if (!stall) begin
				captured_pc_plus = if_pc_plus;
			end
		end
		$display("test passed");
		$finish;
	end

endmodule

// ==== verif/decode_stage_assertions.sv ====
// checker bound into decode_stage for flush gating, valid qualification and missing-word hazard
module decode_stage_assertions (
	input logic                 clk,
	input logic                 rstn,
	input logic                 flush,
	input logic                 rf_we,
	input logic                 mem_we,
	input logic                 mem_re,
	input logic                 branch,
	input logic                 jump,
	input logic                 ex_valid,
	input logic                 stage_valid,
	input logic                 inst_valid,
	input logic                 hazard,
	input rv_decode_pkg::inst_t ex_inst
);

	timeunit 1ns;
	timeprecision 100ps;

	import rv_decode_pkg::*;

	flush_gates_strobes: assert property (@(posedge clk) disable iff (!rstn)
		flush |-> (!rf_we && !mem_we && !mem_re && !branch && !jump && (ex_inst == nop_inst)))
		else $error("flush left a side-effect strobe active or the instruction was not the NOP");

	valid_needs_stage: assert property (@(posedge clk) disable iff (!rstn)
		ex_valid |-> stage_valid)
		else $error("ex_valid high while the stage holds no valid entry");

	missing_inst_stalls: assert property (@(posedge clk) disable iff (!rstn)
		(stage_valid && !inst_valid) |-> hazard)
		else $error("stage valid without an instruction word but no hazard request");

endmodule

bind decode_stage decode_stage_assertions u_assertions (
	.clk         (clk),
	.rstn        (rstn),
	.flush       (flush),
	.rf_we       (rf_we),
	.mem_we      (mem_we),
	.mem_re      (mem_re),
	.branch      (branch),
	.jump        (jump),
	.ex_valid    (ex_valid),
	.stage_valid (stage_valid),
	.inst_valid  (inst_valid),
	.hazard      (hazard),
	.ex_inst     (ex_inst)
);

// ==== verif/tb_clock_gen.sv ====
// testbench clock of 4 ns period and active-low reset held for the first three edges
module tb_clock_gen (
	output logic clk,
	output logic rstn
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// release just after the third rising edge
	initial begin
		rstn = 1'b0;
		repeat (3) @(posedge clk);
		#1 rstn = 1'b1;
	end

endmodule

// ==== design/decode_stage.sv ====
// top level of the RV32I decode stage wiring pipe register, buffer, decoder and hazard check
module decode_stage (
	input  logic                      clk,
	input  logic                      rstn,
	input  logic                      if_valid,
	input  rv_decode_pkg::word_t      if_pc,
	input  rv_decode_pkg::word_t      if_pc_plus,
	input  logic                      imem_valid,
	input  rv_decode_pkg::inst_t      imem_data,
	input  logic                      stall,
	input  logic                      flush,
	input  logic                      ex_mem_re,
	input  rv_decode_pkg::reg_addr_t  ex_rd,
	output logic                      ex_valid,
	output logic                      rf_we,
	output logic                      mem_we,
	output logic                      mem_re,
	output logic                      branch,
	output logic                      jump,
	output logic                      jump_reg,
	output logic                      alu_op1_pc,
	output logic                      alu_op2_imm,
	output rv_decode_pkg::inst_t      ex_inst,
	output rv_decode_pkg::reg_addr_t  rs1,
	output rv_decode_pkg::reg_addr_t  rs2,
	output rv_decode_pkg::reg_addr_t  rd,
	output rv_decode_pkg::alu_op_e    alu_op,
	output rv_decode_pkg::wb_sel_e    wb_sel,
	output rv_decode_pkg::mem_size_e  mem_size,
	output rv_decode_pkg::word_t      ex_pc,
	output rv_decode_pkg::word_t      ex_pc_plus,
	output rv_decode_pkg::word_t      imm,
	output logic                      hazard
);

	import rv_decode_pkg::*;

	logic     stage_valid;
	inst_t    inst;
	logic     inst_valid;
	logic     uses_rs2;
	imm_sel_e imm_sel;

	// registered pc fields go straight to execute
	id_pipe_reg u_pipe_reg (
		.clk           (clk),
		.rstn          (rstn),
		.stall         (stall),
		.if_valid      (if_valid),
		.if_pc         (if_pc),
		.if_pc_plus    (if_pc_plus),
		.stage_valid   (stage_valid),
		.stage_pc      (ex_pc),
		.stage_pc_plus (ex_pc_plus)
	);

	inst_buffer u_inst_buffer (
		.clk         (clk),
		.rstn        (rstn),
		.stall       (stall),
		.stage_valid (stage_valid),
		.imem_valid  (imem_valid),
		.imem_data   (imem_data),
		.inst        (inst),
		.inst_valid  (inst_valid)
	);

	inst_decoder u_decoder (
		.stage_valid (stage_valid),
		.inst_valid  (inst_valid),
		.flush       (flush),
		.inst        (inst),
		.ex_valid    (ex_valid),
		.rf_we       (rf_we),
		.mem_we      (mem_we),
		.mem_re      (mem_re),
		.branch      (branch),
		.jump        (jump),
		.jump_reg    (jump_reg),
		.alu_op1_pc  (alu_op1_pc),
		.alu_op2_imm (alu_op2_imm),
		.uses_rs2    (uses_rs2),
		.ex_inst     (ex_inst),
		.rs1         (rs1),
		.rs2         (rs2),
		.rd          (rd),
		.alu_op      (alu_op),
		.imm_sel     (imm_sel),
		.wb_sel      (wb_sel),
		.mem_size    (mem_size)
	);

	imm_gen u_imm_gen (
		.inst    (inst),
		.imm_sel (imm_sel),
		.imm     (imm)
	);

	hazard_detect u_hazard (
		.ex_mem_re   (ex_mem_re),
		.uses_rs2    (uses_rs2),
		.stage_valid (stage_valid),
		.inst_valid  (inst_valid),
		.ex_rd       (ex_rd),
		.rs1         (rs1),
		.rs2         (rs2),
		.hazard      (hazard)
	);

endmodule

// ==== design/hazard_detect.sv ====
// load-use and missing-instruction stall request toward pipeline control
module hazard_detect (
	input  logic                     ex_mem_re,
	input  logic                     uses_rs2,
	input  logic                     stage_valid,
	input  logic                     inst_valid,
	input  rv_decode_pkg::reg_addr_t ex_rd,
	input  rv_decode_pkg::reg_addr_t rs1,
	input  rv_decode_pkg::reg_addr_t rs2,
	output logic                     hazard
);

	logic rd_eq_rs1;
	logic rd_eq_rs2;
	logic load_use;
	logic inst_missing;

	assign rd_eq_rs1 = (ex_rd == rs1);
	assign rd_eq_rs2 = (ex_rd == rs2);

	// rs2 only counts when the instruction reads it
	assign load_use     = ex_mem_re && (rd_eq_rs1 || (rd_eq_rs2 && uses_rs2));
	assign inst_missing = stage_valid && !inst_valid;

	assign hazard = load_use || inst_missing;

endmodule

// ==== decoder/imm_gen.sv ====
// immediate extraction and sign extension for the RV32I U, J, I, B and S formats
module imm_gen (
	input  rv_decode_pkg::inst_t    inst,
	input  rv_decode_pkg::imm_sel_e imm_sel,
	output rv_decode_pkg::word_t    imm
);

	import rv_decode_pkg::*;

	word_t u_imm;
	word_t j_imm;
	word_t i_imm;
	word_t b_imm;
	word_t s_imm;

	assign u_imm = {inst[31:12], 12'b0};
	// jump and branch offsets are halfword aligned
	assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign i_imm = {{20{inst[31]}}, inst[31:20]};
	assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};

	always_comb begin
		case (imm_sel)
			imm_u:   imm = u_imm;
			imm_j:   imm = j_imm;
			imm_i:   imm = i_imm;
			imm_b:   imm = b_imm;
			imm_s:   imm = s_imm;
			default: imm = '0;
		endcase
	end

endmodule

// ==== decoder/inst_decoder.sv ====
// RV32I opcode and funct decoder producing execute-side control, gated by flush
module inst_decoder (
	input  logic                      stage_valid,
	input  logic                      inst_valid,
	input  logic                      flush,
	input  rv_decode_pkg::inst_t      inst,
	output logic                      ex_valid,
	output logic                      rf_we,
	output logic                      mem_we,
	output logic                      mem_re,
	output logic                      branch,
	output logic                      jump,
	output logic                      jump_reg,
	output logic                      alu_op1_pc,
	output logic                      alu_op2_imm,
	output logic                      uses_rs2,
	output rv_decode_pkg::inst_t      ex_inst,
	output rv_decode_pkg::reg_addr_t  rs1,
	output rv_decode_pkg::reg_addr_t  rs2,
	output rv_decode_pkg::reg_addr_t  rd,
	output rv_decode_pkg::alu_op_e    alu_op,
	output rv_decode_pkg::imm_sel_e   imm_sel,
	output rv_decode_pkg::wb_sel_e    wb_sel,
	output rv_decode_pkg::mem_size_e  mem_size
);

	import rv_decode_pkg::*;

	logic [4:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       f7_is_base;
	logic       f7_is_alt;
	logic       is_lui, is_auipc, is_jal, is_jalr;
	logic       is_branch, is_load, is_store, is_op_imm, is_op_reg;
	logic       sel_sll, sel_srl, sel_sra, sel_sub;

	assign opcode     = inst[6:2];
	assign funct3     = inst[14:12];
	assign funct7     = inst[31:25];
	assign f7_is_base = (funct7 == f7_base);
	assign f7_is_alt  = (funct7 == f7_alt);

	// instruction class, qualified by the registered valid
	assign is_lui    = stage_valid && (opcode == op_lui);
	assign is_auipc  = stage_valid && (opcode == op_auipc);
	assign is_jal    = stage_valid && (opcode == op_jal);
	assign is_jalr   = stage_valid && (opcode == op_jalr);
	assign is_branch = stage_valid && (opcode == op_branch);
	assign is_load   = stage_valid && (opcode == op_load);
	assign is_store  = stage_valid && (opcode == op_store);
	assign is_op_imm = stage_valid && (opcode == op_imm);
	assign is_op_reg = stage_valid && (opcode == op_reg);

	// shifts need funct7 in both forms
	assign sel_sll = (is_op_imm || is_op_reg) && (funct3 == f3_sll) && f7_is_base;
	assign sel_srl = (is_op_imm || is_op_reg) && (funct3 == f3_sr) && f7_is_base;
	assign sel_sra = (is_op_imm || is_op_reg) && (funct3 == f3_sr) && f7_is_alt;
	assign sel_sub = is_op_reg && (funct3 == f3_add) && f7_is_alt;

	always_comb begin
		if (sel_sll) begin
			alu_op = alu_sll;
		end else if (is_branch && (funct3 == f3_beq)) begin
			alu_op = alu_seq;
		end else if (is_branch && (funct3 == f3_bne)) begin
			alu_op = alu_sne;
		end else if ((is_op_imm || is_op_reg) && (funct3 == f3_xor)) begin
			alu_op = alu_xor;
		end else if (sel_srl) begin
			alu_op = alu_srl;
		end else if ((is_op_imm || is_op_reg) && (funct3 == f3_or)) begin
			alu_op = alu_or;
		end else if ((is_op_imm || is_op_reg) && (funct3 == f3_and)) begin
			alu_op = alu_and;
		end else if (sel_sub) begin
			alu_op = alu_sub;
		end else if (sel_sra) begin
			alu_op = alu_sra;
		end else if ((is_branch && (funct3 == f3_blt)) ||
			((is_op_imm || is_op_reg) && (funct3 == f3_slt))) begin
			alu_op = alu_slt;
		end else if (is_branch && (funct3 == f3_bge)) begin
			alu_op = alu_sge;
		end else if ((is_branch && (funct3 == f3_bltu)) ||
			((is_op_imm || is_op_reg) && (funct3 == f3_sltu))) begin
			alu_op = alu_sltu;
		end else if (is_branch && (funct3 == f3_bgeu)) begin
			alu_op = alu_sgeu;
		end else begin
			alu_op = alu_add;
		end
	end

	// stores share the signed byte and half codes
	always_comb begin
		if ((is_load || is_store) && (funct3 == f3_byte)) begin
			mem_size = mem_byte_s;
		end else if (is_load && (funct3 == f3_byte_u)) begin
			mem_size = mem_byte_u;
		end else if ((is_load || is_store) && (funct3 == f3_half)) begin
			mem_size = mem_half_s;
		end else if (is_load && (funct3 == f3_half_u)) begin
			mem_size = mem_half_u;
		end else if ((is_load || is_store) && (funct3 == f3_word)) begin
			mem_size = mem_word;
		end else begin
			mem_size = mem_byte_s;
		end
	end

	// U format falls out as the default
	always_comb begin
		if (is_jal) begin
			imm_sel = imm_j;
		end else if (is_jalr || is_load || is_op_imm) begin
			imm_sel = imm_i;
		end else if (is_branch) begin
			imm_sel = imm_b;
		end else if (is_store) begin
			imm_sel = imm_s;
		end else begin
			imm_sel = imm_u;
		end
	end

	always_comb begin
		if (is_lui) begin
			wb_sel = wb_imm;
		end else if (is_jal || is_jalr) begin
			wb_sel = wb_pc_plus;
		end else if (is_load) begin
			wb_sel = wb_mem;
		end else begin
			wb_sel = wb_alu;
		end
	end

	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign rd  = inst[11:7];

	assign alu_op1_pc  = is_auipc || is_jal;
	assign alu_op2_imm = is_lui || is_auipc || is_jal || is_jalr ||
		is_load || is_store || is_op_imm;
	assign uses_rs2    = is_branch || is_op_reg;
	assign jump_reg    = is_jalr;

	// side effects die under flush
	assign ex_valid = stage_valid && inst_valid && !flush;
	assign rf_we    = !flush && (is_lui || is_auipc || is_jal || is_jalr ||
		is_load || is_op_imm || is_op_reg);
	assign mem_we   = !flush && is_store;
	assign mem_re   = !flush && is_load;
	assign branch   = !flush && is_branch;
	assign jump     = !flush && (is_jal || is_jalr);
	assign ex_inst  = flush ? nop_inst : inst;

endmodule

// ==== design/inst_buffer.sv ====
// one-deep instruction buffer that keeps the decoded word steady across a stall
module inst_buffer (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 stall,
	input  logic                 stage_valid,
	input  logic                 imem_valid,
	input  rv_decode_pkg::inst_t imem_data,
	output rv_decode_pkg::inst_t inst,
	output logic                 inst_valid
);

	import rv_decode_pkg::*;

	logic  frozen;
	logic  freeze_up;
	logic  load_en;
	inst_t buf_word;
	logic  buf_valid;

	// first stalled edge with a live word in the stage
	assign freeze_up = stall && stage_valid && imem_valid && !frozen;
	assign load_en   = !(frozen && stall);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			frozen <= 1'b0;
		end else if (freeze_up) begin
			frozen <= 1'b1;
		end else if (!stall) begin
			frozen <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			buf_valid <= 1'b0;
		end else if (load_en) begin
			buf_valid <= imem_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (load_en) begin
			buf_word <= imem_data;
		end
	end

	// memory may move on while frozen
	assign inst       = frozen ? buf_word : imem_data;
	assign inst_valid = frozen ? buf_valid : imem_valid;

endmodule

// ==== design/id_pipe_reg.sv ====
// fetch-to-decode pipeline register for valid, pc and pc_plus, held while the pipeline stalls
module id_pipe_reg (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 stall,
	input  logic                 if_valid,
	input  rv_decode_pkg::word_t if_pc,
	input  rv_decode_pkg::word_t if_pc_plus,
	output logic                 stage_valid,
	output rv_decode_pkg::word_t stage_pc,
	output rv_decode_pkg::word_t stage_pc_plus
);

	// capture on every edge without stall
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			stage_valid   <= 1'b0;
			stage_pc      <= '0;
			stage_pc_plus <= '0;
		end else if (!stall) begin
			stage_valid   <= if_valid;
			stage_pc      <= if_pc;
			stage_pc_plus <= if_pc_plus;
		end
	end

endmodule

// ==== common/rv_decode_pkg.sv ====
// shared widths, RV32I opcode and funct constants and control encodings, imported by the decode stage
package rv_decode_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;

	// operation seen by the execute stage ALU
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_sll  = 4'd2,
		alu_slt  = 4'd3,
		alu_sltu = 4'd4,
		alu_xor  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_or   = 4'd8,
		alu_and  = 4'd9,
		alu_seq  = 4'd10,
		alu_sne  = 4'd11,
		alu_sge  = 4'd12,
		alu_sgeu = 4'd13
	} alu_op_e;

	typedef enum logic [2:0] {
		imm_u = 3'd0,
		imm_j = 3'd1,
		imm_i = 3'd2,
		imm_b = 3'd3,
		imm_s = 3'd4
	} imm_sel_e;

	typedef enum logic [2:0] {
		mem_byte_s = 3'd0,
		mem_byte_u = 3'd1,
		mem_half_s = 3'd2,
		mem_half_u = 3'd3,
		mem_word   = 3'd4
	} mem_size_e;

	// source of the register write-back value
	typedef enum logic [1:0] {
		wb_alu     = 2'd0,
		wb_imm     = 2'd1,
		wb_pc_plus = 2'd2,
		wb_mem     = 2'd3
	} wb_sel_e;

	// major opcodes, instruction bits 6 to 2
	localparam logic [4:0] op_lui    = 5'b01101;
	localparam logic [4:0] op_auipc  = 5'b00101;
	localparam logic [4:0] op_jal    = 5'b11011;
	localparam logic [4:0] op_jalr   = 5'b11001;
	localparam logic [4:0] op_branch = 5'b11000;
	localparam logic [4:0] op_load   = 5'b00000;
	localparam logic [4:0] op_store  = 5'b01000;
	localparam logic [4:0] op_imm    = 5'b00100;
	localparam logic [4:0] op_reg    = 5'b01100;

	// branch conditions
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// load and store widths share one encoding
	localparam logic [2:0] f3_byte   = 3'b000;
	localparam logic [2:0] f3_half   = 3'b001;
	localparam logic [2:0] f3_word   = 3'b010;
	localparam logic [2:0] f3_byte_u = 3'b100;
	localparam logic [2:0] f3_half_u = 3'b101;

	// alu forms, immediate and register
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000;

	// addi x0, x0, 0
	localparam inst_t nop_inst = 32'h0000_0013;

endpackage
